// ==== design/robPkg.sv ====
/*
  ROB package
  Tag types shared by the reorder buffer side of the core.
  A tag names one ROB entry and travels on the common data bus
  as the identity of every broadcast result
*/
package robPkg;

  // Eight ROB entries in this core
  localparam int ROB_DEPTH = 8;

  // ROB entry number, used as the rename tag of a result
  typedef logic [$clog2(ROB_DEPTH)-1:0] robTag;

endpackage

// ==== design/aluPkg.sv ====
/*
  ALU package
  Operand word type, the ALU operation encoding and the
  states of the broadcast stage behind the ALU
*/
package aluPkg;

  localparam int DATA_WIDTH = 32;
  localparam int SHIFT_BITS = 5;   // Shift amount taken from source 2

  // Signed operand and result word
  typedef logic signed [DATA_WIDTH-1:0] aluWord;

  // ALU operations, 4-bit encoding
  typedef enum logic [3:0] {
    opAdd,
    opSub,
    opAnd,
    opOr,
    opXor,
    opSlt,   // Signed set-less-than
    opSll,
    opSrl    // Logical right shift
  } aluOp;

  // Broadcast stage, stHold while the bus is taken by another unit
  typedef enum logic {
    stIdle,
    stHold
  } execState;

endpackage

// ==== design/commonDataBus.sv ====
/*
  Common data bus
  One result broadcast per cycle, tagged with its ROB entry.
  The ALU broadcast stage drives it, every reservation station
  entry snoops it
*/
`timescale 1ns/1ps

interface commonDataBus;
  import robPkg::*;
  import aluPkg::*;

  logic   validBroadcast;  // One-cycle strobe
  robTag  robEntry;        // Producer tag
  aluWord result;          // Produced value

  modport broadcaster (
    output validBroadcast,
    output robEntry,
    output result
  );

  modport reservationStation (
    input validBroadcast,
    input robEntry,
    input result
  );

endinterface

// ==== design/rsIssuePort.sv ====
/*
  Issue port
  Carries one decoded ALU instruction with its two source operands
  into the reservation station. Each source is either a ready value
  or the ROB tag that will produce it
*/
`timescale 1ns/1ps

interface rsIssuePort;
  import robPkg::*;
  import aluPkg::*;

  aluOp   aluControl;  // Operation
  robTag  robInstr;    // Destination ROB entry
  logic   ready1;      // Source 1 value valid
  aluWord value1;
  robTag  rob1;        // Source 1 producer when not ready
  logic   ready2;
  aluWord value2;
  robTag  rob2;

  modport issuer (
    output aluControl, robInstr,
    output ready1, value1, rob1,
    output ready2, value2, rob2
  );

  modport entry (
    input aluControl, robInstr,
    input ready1, value1, rob1,
    input ready2, value2, rob2
  );

endinterface

// ==== design/aluRsEntry.sv ====
/*
  ALU reservation station entry
  Holds one instruction with its ROB tag and two operands.
  A missing operand is captured from the CDB when its producer tag
  is broadcast, also in the issue cycle itself. With both operands
  present the entry asks the selector for execution
*/
`timescale 1ns/1ps

module aluRsEntry (
  input  logic                            clk,
  input  logic                            rst,
  rsIssuePort.entry                       issue,
  commonDataBus.reservationStation        dataBus,
  input  logic                            writeReq,
  input  logic                            selected,
  input  logic                            clear,
  output logic                            busy,
  output logic                            selectReq,
  output robPkg::robTag                   instrRob,
  output aluPkg::aluOp                    instrInfo,
  output aluPkg::aluWord                  src1,
  output aluPkg::aluWord                  src2
);
  import robPkg::*;

  logic  op1Ready;   // Operand 1 value held
  logic  op2Ready;
  robTag src1Rob;    // Producer tags of pending operands
  robTag src2Rob;
  logic  match1;     // CDB hit on a pending operand
  logic  match2;
  logic  issueHit1;  // Operand broadcast in the issue cycle
  logic  issueHit2;

  // Two tag comparators for the stored sources, two for the issue fields
  always_comb begin
    match1    = dataBus.validBroadcast & busy & ~op1Ready & (dataBus.robEntry == src1Rob);
    match2    = dataBus.validBroadcast & busy & ~op2Ready & (dataBus.robEntry == src2Rob);
    issueHit1 = dataBus.validBroadcast & ~issue.ready1 & (dataBus.robEntry == issue.rob1);
    issueHit2 = dataBus.validBroadcast & ~issue.ready2 & (dataBus.robEntry == issue.rob2);
  end

  // Only registered readiness counts, so a new entry waits one cycle
  assign selectReq = busy & op1Ready & op2Ready;

  // Occupancy and operand flags
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      busy     <= 1'b0;
      op1Ready <= 1'b0;
      op2Ready <= 1'b0;
    end else if (writeReq) begin
      busy     <= 1'b1;
      op1Ready <= issue.ready1 | issueHit1;
      op2Ready <= issue.ready2 | issueHit2;
    end else begin
      if (selected) busy <= 1'b0;  // Leaves for the ALU at this edge
      if (match1) op1Ready <= 1'b1;
      if (match2) op2Ready <= 1'b1;
    end
  end

  // Instruction fields and operand values
  always_ff @(posedge clk) begin
    if (writeReq) begin
      instrRob  <= issue.robInstr;
      instrInfo <= issue.aluControl;
      src1Rob   <= issue.rob1;
      src2Rob   <= issue.rob2;
      src1      <= issueHit1 ? dataBus.result : issue.value1;
      src2      <= issueHit2 ? dataBus.result : issue.value2;
    end else begin
      if (match1) src1 <= dataBus.result;  // Wakeup capture
      if (match2) src2 <= dataBus.result;
    end
  end

  // Selector must only write into a free entry
  writeOnlyWhenFree: assert property (
    @(posedge clk) disable iff (rst)
    writeReq |-> !busy
  ) else $error("aluRsEntry: write into busy entry, tag %0d lost", instrRob);

  // A grant needs a complete instruction
  selectOnlyWhenReady: assert property (
    @(posedge clk) disable iff (rst)
    selected |-> selectReq
  ) else $error("aluRsEntry: selected without both operands");

endmodule

// ==== design/aluRsSelect.sv ====
/*
  Reservation station selector
  Fixed priority, lowest index first, in both directions.
  Issue goes to the lowest free entry, execution is granted to the
  lowest entry with both operands ready while the ALU accepts
*/
`timescale 1ns/1ps

module aluRsSelect #(
  parameter int ENTRIES = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [ENTRIES-1:0]         busy,
  input  logic [ENTRIES-1:0]         selectReq,
  input  logic                       issueValid,
  input  logic                       execute,
  output logic [ENTRIES-1:0]         writeReq,
  output logic [ENTRIES-1:0]         selected,
  output logic                       full,
  output logic                       grant,
  output logic [$clog2(ENTRIES)-1:0] grantIdx
);

  localparam int IDX_WIDTH = $clog2(ENTRIES);

  logic [ENTRIES-1:0] freeOne;   // One-hot lowest free entry
  logic [ENTRIES-1:0] readyOne;  // One-hot lowest requesting entry

  assign full = &busy;  // No free slot left

  // Scan downwards so the lowest hit is the last one kept
  always_comb begin
    freeOne  = '0;
    readyOne = '0;
    grantIdx = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        freeOne    = '0;
        freeOne[i] = 1'b1;
      end
      if (selectReq[i]) begin
        readyOne    = '0;
        readyOne[i] = 1'b1;
        grantIdx    = IDX_WIDTH'(i);
      end
    end
  end

  always_comb begin
    writeReq = freeOne & {ENTRIES{issueValid & ~full}};
    selected = readyOne & {ENTRIES{execute}};  // ALU stalled, nobody leaves
    grant    = |selected;
  end

  // One write and one grant per cycle at most
  singleWriteAndGrant: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(writeReq) && $onehot0(selected)
  ) else $error("aluRsSelect: more than one write or grant");

  // A rejected issue must not write any entry
  noIssueWhenFull: assert property (
    @(posedge clk) disable iff (rst)
    (issueValid && full) |-> !(|writeReq)
  ) else $error("aluRsSelect: entry filled by an issue seen while full");

endmodule

// ==== design/aluExec.sv ====
/*
  ALU and CDB broadcast stage
  Granted operands are registered, the ALU result is registered one
  cycle later and then broadcast. An external broadcast has priority,
  the ALU result then waits in stHold and no new grant is given
*/
`timescale 1ns/1ps

module aluExec (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush,
  input  logic                     grant,
  input  aluPkg::aluOp             op,
  input  robPkg::robTag            rob,
  input  aluPkg::aluWord           a,
  input  aluPkg::aluWord           b,
  input  logic                     extCdbValid,
  input  robPkg::robTag            extCdbRob,
  input  aluPkg::aluWord           extCdbResult,
  output logic                     execute,
  commonDataBus.broadcaster        dataBus
);
  import robPkg::*;
  import aluPkg::*;

  execState state;
  execState stateNext;
  logic     exValid;    // Operand stage occupied
  aluOp     exOp;
  robTag    exRob;
  aluWord   exA;
  aluWord   exB;
  logic     resValid;   // Result register occupied
  robTag    resRob;
  aluWord   resValue;
  aluWord   aluResult;
  logic     stall;      // Result loses the bus this cycle

  assign stall   = resValid & extCdbValid;
  assign execute = (state == stIdle) & ~stall;  // Bubble also in the release cycle

  always_comb begin
    unique case (exOp)
      opAdd:   aluResult = exA + exB;
      opSub:   aluResult = exA - exB;
      opAnd:   aluResult = exA & exB;
      opOr:    aluResult = exA | exB;
      opXor:   aluResult = exA ^ exB;
      opSlt:   aluResult = (exA < exB) ? aluWord'(1) : '0;  // Signed compare
      opSll:   aluResult = exA << exB[SHIFT_BITS-1:0];
      opSrl:   aluResult = $unsigned(exA) >> exB[SHIFT_BITS-1:0];
      default: aluResult = '0;
    endcase
  end

  // Pipeline occupancy, frozen while the result waits
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      exValid  <= 1'b0;
      resValid <= 1'b0;
    end else if (!stall) begin
      exValid  <= grant;
      resValid <= exValid;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin  // Granted entry fields
      exOp <= op;
      exRob <= rob;
      exA  <= a;
      exB  <= b;
    end
    if (!stall && exValid) begin
      resRob   <= exRob;
      resValue <= aluResult;
    end
  end

  always_comb begin
    stateNext = state;
    unique case (state)
      stIdle: if (stall) stateNext = stHold;
      stHold: if (!extCdbValid) stateNext = stIdle;  // Held result goes out now
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || flush) state <= stIdle;
    else              state <= stateNext;
  end

  // External unit first, ALU result otherwise
  always_comb begin
    dataBus.validBroadcast = extCdbValid | resValid;
    dataBus.robEntry       = extCdbValid ? extCdbRob : resRob;
    dataBus.result         = extCdbValid ? extCdbResult : resValue;
  end

  // A displaced result stays intact until it reaches the bus
  heldResultKept: assert property (
    @(posedge clk) disable iff (rst || flush)
    stall |=> resValid && (resRob == $past(resRob)) && (resValue == $past(resValue))
  ) else $error("aluExec: held result for tag %0d overwritten", $past(resRob));

endmodule

// ==== design/aluReservationStation.sv ====
/*
  ALU reservation station, top level
  ENTRIES entries share one issue port and snoop one CDB. The
  selector picks the entry to fill and the entry to execute, the
  granted entry's fields are steered into the ALU, whose broadcast
  stage drives the CDB together with the external result bus
*/
`timescale 1ns/1ps

module aluReservationStation #(
  parameter int ENTRIES = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           flush,
  input  logic           issueValid,
  input  aluPkg::aluOp   issueOp,
  input  robPkg::robTag  issueRob,
  input  logic           src1Ready,
  input  logic           src2Ready,
  input  aluPkg::aluWord src1Value,
  input  aluPkg::aluWord src2Value,
  input  robPkg::robTag  src1Rob,
  input  robPkg::robTag  src2Rob,
  output logic           full,
  input  logic           extCdbValid,
  input  robPkg::robTag  extCdbRob,
  input  aluPkg::aluWord extCdbResult,
  output logic           cdbValid,
  output robPkg::robTag  cdbRob,
  output aluPkg::aluWord cdbResult
);
  import robPkg::*;
  import aluPkg::*;

  logic [ENTRIES-1:0]         busy;
  logic [ENTRIES-1:0]         selectReq;
  logic [ENTRIES-1:0]         writeReq;
  logic [ENTRIES-1:0]         selected;
  robTag                      entRob [ENTRIES];   // Per-entry fields
  aluOp                       entOp [ENTRIES];
  aluWord                     entSrc1 [ENTRIES];
  aluWord                     entSrc2 [ENTRIES];
  logic                       grant;
  logic [$clog2(ENTRIES)-1:0] grantIdx;
  logic                       execute;   // ALU accepts a grant

  commonDataBus cdb ();
  rsIssuePort   issueBus ();  // Shared by all entries

  assign issueBus.aluControl = issueOp;
  assign issueBus.robInstr   = issueRob;
  assign issueBus.ready1     = src1Ready;
  assign issueBus.value1     = src1Value;
  assign issueBus.rob1       = src1Rob;
  assign issueBus.ready2     = src2Ready;
  assign issueBus.value2     = src2Value;
  assign issueBus.rob2       = src2Rob;

  for (genvar i = 0; i < ENTRIES; i++) begin : gEntry
    aluRsEntry i_entry (
      .clk       (clk),
      .rst       (rst),
      .issue     (issueBus),
      .dataBus   (cdb),
      .writeReq  (writeReq[i]),
      .selected  (selected[i]),
      .clear     (flush),
      .busy      (busy[i]),
      .selectReq (selectReq[i]),
      .instrRob  (entRob[i]),
      .instrInfo (entOp[i]),
      .src1      (entSrc1[i]),
      .src2      (entSrc2[i])
    );
  end

  aluRsSelect #(
    .ENTRIES (ENTRIES)
  ) i_select (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .selectReq  (selectReq),
    .issueValid (issueValid),
    .execute    (execute),
    .writeReq   (writeReq),
    .selected   (selected),
    .full       (full),
    .grant      (grant),
    .grantIdx   (grantIdx)
  );

  // Granted entry steered into the ALU, don't care without grant
  aluExec i_exec (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .grant        (grant),
    .op           (entOp[grantIdx]),
    .rob          (entRob[grantIdx]),
    .a            (entSrc1[grantIdx]),
    .b            (entSrc2[grantIdx]),
    .extCdbValid  (extCdbValid),
    .extCdbRob    (extCdbRob),
    .extCdbResult (extCdbResult),
    .execute      (execute),
    .dataBus      (cdb)
  );

  // CDB also leaves the station for the ROB
  assign cdbValid  = cdb.validBroadcast;
  assign cdbRob    = cdb.robEntry;
  assign cdbResult = cdb.result;

endmodule

// ==== bench/aluRsTb.sv ====
/*
  Testbench for the ALU reservation station
  Issues a table of ALU instructions, injects external CDB broadcasts
  and checks every own broadcast by ROB tag against a reference model,
  independent of the order in which results leave the station
*/
`timescale 1ns/1ps

module aluRsTb;
  import robPkg::*;
  import aluPkg::*;

  localparam int ISSUE_TIMEOUT = 100;  // Cycles an issue may wait on full
  localparam int DONE_TIMEOUT  = 200;  // Cycles until all results of a test are seen
  localparam int DRAIN_CYCLES  = 12;   // Quiet window for late or doubled broadcasts

  typedef struct {
    int     testId;
    int     stallRule;   // 0 no wait on full, 1 must wait, 2 either
    bit     flushFirst;  // Pulse flush before this issue
    aluOp   op;
    robTag  rob;
    logic   rdy1;
    aluWord val1;        // Value driven on the issue port
    robTag  tag1;
    logic   rdy2;
    aluWord val2;
    robTag  tag2;
    bit     produces;    // Result expected on the CDB within this test
    aluWord expected;
    int     extDelay;    // Cycles after issue, -1 for no injection
    int     extLen;
    robTag  extRob;
    aluWord extVal;
  } stimRow;

  logic   clk = 1'b0;
  logic   rst = 1'b1;
  logic   flush = 1'b0;
  logic   issueValid = 1'b0;
  aluOp   issueOp = opAdd;
  robTag  issueRob = '0;
  logic   src1Ready = 1'b0;
  logic   src2Ready = 1'b0;
  aluWord src1Value = '0;
  aluWord src2Value = '0;
  robTag  src1Rob = '0;
  robTag  src2Rob = '0;
  logic   extCdbValid = 1'b0;
  robTag  extCdbRob = '0;
  aluWord extCdbResult = '0;
  logic   full;
  logic   cdbValid;
  robTag  cdbRob;
  aluWord cdbResult;

  stimRow rows[$];
  int     seed = 29;
  int     errors = 0;
  int     passCount = 0;
  int     failCount = 0;
  int     testErrStart;
  int     curTest;
  bit     expectTag [8];   // Tags this test must broadcast
  aluWord expValue [8];
  int     seenCount [8];
  string  testName [6] = '{"eight ops, ready operands", "wakeup from external broadcast",
                           "dependent chain", "full with five waiting",
                           "flush of waiting entries", "external bus held"};

  always #4 clk = ~clk;

  aluReservationStation #(.ENTRIES(4)) i_dut (.*);

  // Expected result from the operation rule
  function automatic aluWord computeExpected(input aluOp op, input aluWord a, input aluWord b);
    logic [4:0]  sh;
    logic [31:0] ua;
    sh = b[4:0];   // Shift amount, low 5 bits of source 2
    ua = a;
    case (op)
      opAdd:   return a + b;
      opSub:   return a - b;
      opAnd:   return a & b;
      opOr:    return a | b;
      opXor:   return a ^ b;
      opSlt:   return {31'b0, (a < b)};  // Both signed
      opSll:   return a << sh;
      opSrl:   return ua >> sh;          // Zero fill
      default: return '0;
    endcase
  endfunction

  // val1/val2 are the known or resolved source values
  task automatic addRow(input int id, input int stallRule, input aluOp op, input int rob,
                        input bit rdy1, input aluWord val1, input int tag1,
                        input bit rdy2, input aluWord val2, input int tag2,
                        input bit produces);
    stimRow r;
    r.testId     = id;
    r.stallRule  = stallRule;
    r.flushFirst = 1'b0;
    r.op         = op;
    r.rob        = robTag'(rob);
    r.rdy1       = rdy1;
    r.val1       = rdy1 ? val1 : aluWord'($random(seed));  // Junk while pending
    r.tag1       = robTag'(tag1);
    r.rdy2       = rdy2;
    r.val2       = rdy2 ? val2 : aluWord'($random(seed));
    r.tag2       = robTag'(tag2);
    r.produces   = produces;
    r.expected   = computeExpected(op, val1, val2);
    r.extDelay   = -1;
    r.extLen     = 0;
    r.extRob     = '0;
    r.extVal     = '0;
    rows.push_back(r);
  endtask

  task automatic addInjection(input int delay, input int len, input int tag, input aluWord value);
    rows[rows.size()-1].extDelay = delay;
    rows[rows.size()-1].extLen   = len;
    rows[rows.size()-1].extRob   = robTag'(tag);
    rows[rows.size()-1].extVal   = value;
  endtask

  function automatic aluWord lastResult();
    return rows[rows.size()-1].expected;
  endfunction

  task automatic buildTable();
    aluWord x;
    for (int k = 0; k < 8; k++)   // All ops, tags 0 to 7
      addRow(1, 2, aluOp'(k), k, 1, $random(seed), 0, 1, $random(seed), 0, 1);
    x = $random(seed);
    addRow(2, 0, opSub, 1, 0, x, 5, 1, $random(seed), 0, 1);
    addInjection(2, 1, 5, x);
    addRow(3, 0, opAdd, 2, 1, $random(seed), 0, 1, $random(seed), 0, 1);
    addRow(3, 0, opSub, 3, 0, lastResult(), 2, 1, $random(seed), 0, 1);
    addRow(3, 0, opSll, 4, 0, lastResult(), 3, 1, $random(seed), 0, 1);
    addRow(3, 0, opAnd, 5, 1, $random(seed), 0, 0, lastResult(), 4, 1);
    x = $random(seed);
    addRow(4, 0, opXor, 0, 0, x, 6, 1, $random(seed), 0, 1);
    for (int k = 1; k < 4; k++)   // Tag 7 never comes
      addRow(4, 0, opOr, k, 0, '0, 7, 1, $random(seed), 0, 0);
    addInjection(0, 1, 6, x);     // Wakes entry 0 only
    addRow(4, 1, opAdd, 4, 0, '0, 7, 1, $random(seed), 0, 0);
    addRow(5, 0, opSlt, 5, 1, $random(seed), 0, 1, $random(seed), 0, 1);
    rows[rows.size()-1].flushFirst = 1'b1;
    addInjection(1, 1, 7, $random(seed));  // Late producer of the flushed tags
    addRow(6, 0, opSrl, 0, 1, $random(seed), 0, 1, $random(seed), 0, 1);
    addRow(6, 0, opSll, 1, 1, $random(seed), 0, 1, $random(seed), 0, 1);
    addRow(6, 0, opSlt, 2, 1, $random(seed), 0, 1, $random(seed), 0, 1);
    addInjection(0, 5, 6, $random(seed));
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic issueRow(input stimRow r);
    int cycles;
    int stalls;
    bit accepted;
    cycles   = 0;
    stalls   = 0;
    accepted = 0;
    if (r.flushFirst) begin
      if (full !== 1'b1) begin
        errors++;
        $display("test %0d: full was not high with waiting entries before flush", r.testId);
      end
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      if (full !== 1'b0) begin
        errors++;
        $display("test %0d: full did not drop after flush", r.testId);
      end
    end
    issueValid = 1'b1;
    issueOp    = r.op;
    issueRob   = r.rob;
    src1Ready  = r.rdy1;
    src1Value  = r.val1;
    src1Rob    = r.tag1;
    src2Ready  = r.rdy2;
    src2Value  = r.val2;
    src2Rob    = r.tag2;
    while (!accepted && cycles < ISSUE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (full === 1'b1) stalls++;  // Issuer holds the instruction
      else accepted = 1;
    end
    @(negedge clk);
    issueValid = 1'b0;
    if (!accepted) begin
      errors++;
      $display("TIMEOUT: tag %0d was never accepted, full stayed high", r.rob);
    end else if (r.stallRule == 0 && stalls > 0) begin
      errors++;
      $display("test %0d: tag %0d had to wait on full with a free entry", r.testId, r.rob);
    end else if (r.stallRule == 1 && stalls == 0) begin
      errors++;
      $display("test %0d: tag %0d accepted while all entries were waiting", r.testId, r.rob);
    end
    if (accepted && r.produces) begin
      expectTag[r.rob] = 1'b1;
      expValue[r.rob]  = r.expected;
    end
    if (r.extDelay >= 0) begin
      repeat (r.extDelay) @(negedge clk);
      extCdbValid  = 1'b1;
      extCdbRob    = r.extRob;
      extCdbResult = r.extVal;
      repeat (r.extLen) @(negedge clk);
      extCdbValid  = 1'b0;
    end
  endtask

  task automatic startTest(input int id);
    for (int t = 0; t < 8; t++) begin
      expectTag[t] = 1'b0;
      expValue[t]  = '0;
      seenCount[t] = 0;
    end
    testErrStart = errors;
    curTest      = id;
  endtask

  task automatic finishTest(input int id);
    int cycles;
    bit allSeen;
    cycles  = 0;
    allSeen = 0;
    while (!allSeen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      allSeen = 1;
      for (int t = 0; t < 8; t++)
        if (expectTag[t] && seenCount[t] == 0) allSeen = 0;
    end
    repeat (DRAIN_CYCLES) @(negedge clk);  // Doubles and flushed tags show up here
    for (int t = 0; t < 8; t++) begin
      if (expectTag[t] && seenCount[t] == 0) begin
        errors++;
        $display("TIMEOUT: test %0d never broadcast the result for tag %0d", id, t);
      end
    end
    if (errors == testErrStart) begin
      passCount++;
      $display("test %0d %s: PASS", id, testName[id-1]);
    end else begin
      failCount++;
      $display("test %0d %s: FAIL, %0d errors", id, testName[id-1], errors - testErrStart);
    end
  endtask

  // CDB monitor, sees the values from before the edge
  always @(posedge clk) begin
    if (!rst && extCdbValid) begin   // External unit owns the bus
      if (cdbRob !== extCdbRob) begin
        errors++;
        $display("MISMATCH time=%0t cdbRob expected=%0d actual=%0d", $time, extCdbRob, cdbRob);
      end
      if (cdbResult !== extCdbResult) begin
        errors++;
        $display("MISMATCH time=%0t cdbResult expected=%h actual=%h",
                 $time, extCdbResult, cdbResult);
      end
    end else if (!rst && cdbValid === 1'b1) begin
      seenCount[cdbRob]++;
      if (!expectTag[cdbRob]) begin
        errors++;
        $display("test %0d: unexpected broadcast of tag %0d at %0t", curTest, cdbRob, $time);
      end else if (seenCount[cdbRob] > 1) begin
        errors++;
        $display("test %0d: tag %0d broadcast a second time at %0t", curTest, cdbRob, $time);
      end else if (cdbResult !== expValue[cdbRob]) begin
        errors++;
        $display("MISMATCH time=%0t cdbResult tag=%0d expected=%h actual=%h",
                 $time, cdbRob, expValue[cdbRob], cdbResult);
      end
    end
  end

  initial begin
    curTest = 0;
    buildTable();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (full !== 1'b0 || cdbValid !== 1'b0) begin
      errors++;
      $display("full or cdbValid not low after reset");
    end
    foreach (rows[i]) begin
      if (rows[i].testId != curTest) begin
        if (curTest != 0) finishTest(curTest);
        startTest(rows[i].testId);
      end
      issueRow(rows[i]);
    end
    finishTest(curTest);
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             passCount + failCount, passCount, failCount, errors);
    if (errors == 0) $display("ALL TESTS PASSED");
    else $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
design/robPkg.sv
design/aluPkg.sv
design/commonDataBus.sv
design/rsIssuePort.sv
design/aluRsEntry.sv
design/aluRsSelect.sv
design/aluExec.sv
design/aluReservationStation.sv
bench/aluRsTb.sv

// ==== Bender.yml ====
package:
  name: alu_reservation_station

sources:
  # Packages and interfaces before the modules that use them
  - design/robPkg.sv
  - design/aluPkg.sv
  - design/commonDataBus.sv
  - design/rsIssuePort.sv
  - design/aluRsEntry.sv
  - design/aluRsSelect.sv
  - design/aluExec.sv
  - design/aluReservationStation.sv
  # Testbench, top module aluRsTb
  - target: test
    files:
      - bench/aluRsTb.sv
